//--- logic/alarmTimePkg.sv
// clock-time types shared by the alarm trigger, the top level and the testbench
package alarmTimePkg;

   // minutes and seconds both fit in 7 bits (0..59)
   localparam int timeWidth = 7;

   typedef logic [timeWidth-1:0] timeField;

   // minute and second compared as one value
   typedef struct packed
   {
      timeField min;
      timeField sec;
   } clockTime;

endpackage

//--- logic/scorePkg.sv
// score types, note half-periods and durations used by the ROM, sequencer and tone generator
package scorePkg;

   localparam int periodWidth   = 13;
   localparam int durationWidth = 4;
   localparam int indexWidth    = 5;

   typedef logic [periodWidth-1:0]   notePeriod;   // half-period in clocks
   typedef logic [durationWidth-1:0] noteDuration; // thirty-second units
   typedef logic [indexWidth-1:0]    scoreIndex;

   // period 0 marks a rest
   localparam notePeriod restCode = '0;

   localparam int scoreLength = 21;

   typedef struct packed
   {
      notePeriod   period;
      noteDuration duration;
   } scoreEntry;

   // half-periods at the real clock rate
   localparam notePeriod B1  = 13'd4049;
   localparam notePeriod C2  = 13'd3822;
   localparam notePeriod D2  = 13'd3405;
   localparam notePeriod F2  = 13'd2863;
   localparam notePeriod G2  = 13'd2551;
   localparam notePeriod GS2 = 13'd2407;
   localparam notePeriod A2  = 13'd2272;
   localparam notePeriod D3  = 13'd1702;

   localparam noteDuration thirtySecond = 4'd1;
   localparam noteDuration sixteenth    = 4'd2;
   localparam noteDuration eighth       = 4'd4;

   typedef enum logic
   {
      idle,
      playing
   } playerState;

endpackage

//--- logic/alarmTrigger.sv
// matches the clock time against the alarm time and starts or stops the score player
`timescale 1ns/1ps

module alarmTrigger
(
   input  logic                  CLK,
   input  logic                  arstN,
   input  logic                  alarmActive,
   input  alarmTimePkg::timeField currentMin,
   input  alarmTimePkg::timeField currentSec,
   input  alarmTimePkg::timeField alarmMin,
   input  alarmTimePkg::timeField alarmSec,
   input  logic                  scoreDone,
   output logic                  startPulse,
   output logic                  stop
);

   alarmTimePkg::clockTime nowTime;
   alarmTimePkg::clockTime alarmTime;
   logic timesMatch;
   logic armed;
   logic busy;   // a score is running
   logic fire;

   assign nowTime   = '{min: currentMin, sec: currentSec};
   assign alarmTime = '{min: alarmMin, sec: alarmSec};
   assign timesMatch = (nowTime == alarmTime);

   assign stop = !alarmActive;
   assign fire = !stop && armed && !busy && timesMatch;

   always_ff @(posedge CLK or negedge arstN)
   begin
      if (!arstN)
      begin
         armed      <= 1'b0;
         busy       <= 1'b0;
         startPulse <= 1'b0;
      end
      else
      begin
         startPulse <= fire;
         // one start per match; re-arm once the times part or the alarm is off
         if (fire)
            armed <= 1'b0;
         else if (!timesMatch || stop)
            armed <= 1'b1;
         if (fire)
            busy <= 1'b1;
         else if (scoreDone || stop)
            busy <= 1'b0;
      end
   end

endmodule

//--- logic/scoreRom.sv
// combinational table holding the first bar of the alarm melody
`timescale 1ns/1ps

module scoreRom
(
   input  scorePkg::scoreIndex index,
   output scorePkg::scoreEntry entry
);

   always_comb
   begin
      case (index)
         5'd0:
            entry = '{period: scorePkg::D2, duration: scorePkg::thirtySecond};
         5'd1:
            entry = '{period: scorePkg::restCode, duration: scorePkg::thirtySecond};
         5'd2:
            entry = '{period: scorePkg::D2, duration: scorePkg::thirtySecond};
         5'd3:
            entry = '{period: scorePkg::restCode, duration: scorePkg::thirtySecond};
         5'd4:
            entry = '{period: scorePkg::D3, duration: scorePkg::sixteenth};
         5'd5:
            entry = '{period: scorePkg::restCode, duration: scorePkg::sixteenth};
         5'd6:
            entry = '{period: scorePkg::A2, duration: scorePkg::sixteenth};
         5'd7:
            entry = '{period: scorePkg::restCode, duration: scorePkg::sixteenth};
         5'd8:
            entry = '{period: scorePkg::restCode, duration: scorePkg::sixteenth};
         5'd9:
            entry = '{period: scorePkg::GS2, duration: scorePkg::thirtySecond};
         5'd10:
            entry = '{period: scorePkg::restCode, duration: scorePkg::thirtySecond};
         5'd11:
            entry = '{period: scorePkg::restCode, duration: scorePkg::sixteenth};
         5'd12:
            entry = '{period: scorePkg::G2, duration: scorePkg::sixteenth};
         5'd13:
            entry = '{period: scorePkg::restCode, duration: scorePkg::sixteenth};
         5'd14:
            entry = '{period: scorePkg::F2, duration: scorePkg::eighth};
         5'd15:
            entry = '{period: scorePkg::D2, duration: scorePkg::thirtySecond};
         5'd16:
            entry = '{period: scorePkg::restCode, duration: scorePkg::thirtySecond};
         5'd17:
            entry = '{period: scorePkg::F2, duration: scorePkg::thirtySecond};
         5'd18:
            entry = '{period: scorePkg::restCode, duration: scorePkg::thirtySecond};
         5'd19:
            entry = '{period: scorePkg::G2, duration: scorePkg::thirtySecond};
         5'd20:
            entry = '{period: scorePkg::restCode, duration: scorePkg::thirtySecond};
         // past the end of the bar
         default:
            entry = '{period: scorePkg::restCode, duration: scorePkg::thirtySecond};
      endcase
   end

endmodule

//--- logic/scoreSequencer.sv
// walks through the score and times each entry in units of durationUnit clocks
`timescale 1ns/1ps

module scoreSequencer
#(
   parameter int durationUnit = 62500
)
(
   input  logic                CLK,
   input  logic                arstN,
   input  logic                startPulse,
   input  logic                stop,
   output scorePkg::scoreIndex index,
   input  scorePkg::scoreEntry romEntry,
   output scorePkg::scoreEntry entry,
   output logic                playing,
   output logic                entryStart,
   output logic                scoreDone
);

   localparam int cntWidth = (durationUnit > 1) ? $clog2(durationUnit) : 1;
   localparam scorePkg::scoreIndex lastIndex = scorePkg::scoreIndex'(scorePkg::scoreLength - 1);

   scorePkg::playerState  state;
   logic [cntWidth-1:0]   cycleCnt;  // clocks within the current unit
   scorePkg::noteDuration unitCnt;   // units within the current entry
   logic unitDone;
   logic lastUnit;

   assign unitDone = (cycleCnt == cntWidth'(durationUnit - 1));
   assign lastUnit = (unitCnt == romEntry.duration - scorePkg::noteDuration'(1));

   // stop silences the tone without waiting for the edge
   assign playing = (state == scorePkg::playing) && !stop;
   assign entry   = romEntry;

   always_ff @(posedge CLK or negedge arstN)
   begin
      if (!arstN)
      begin
         state      <= scorePkg::idle;
         index      <= '0;
         cycleCnt   <= '0;
         unitCnt    <= '0;
         entryStart <= 1'b0;
         scoreDone  <= 1'b0;
      end
      else
      begin
         entryStart <= 1'b0;
         scoreDone  <= 1'b0;
         case (state)
            scorePkg::idle:
            begin
               if (startPulse && !stop)
               begin
                  state      <= scorePkg::playing;
                  index      <= '0;
                  cycleCnt   <= '0;
                  unitCnt    <= '0;
                  entryStart <= 1'b1;
               end
            end
            scorePkg::playing:
            begin
               if (stop)
                  state <= scorePkg::idle;   // cancelled, no scoreDone
               else if (!unitDone)
                  cycleCnt <= cycleCnt + cntWidth'(1);
               else
               begin
                  cycleCnt <= '0;
                  if (!lastUnit)
                     unitCnt <= unitCnt + scorePkg::noteDuration'(1);
                  else
                  begin
                     unitCnt <= '0;
                     if (index == lastIndex)
                     begin
                        state     <= scorePkg::idle;
                        scoreDone <= 1'b1;
                     end
                     else
                     begin
                        index      <= index + scorePkg::scoreIndex'(1);
                        entryStart <= 1'b1;
                     end
                  end
               end
            end
            default:
               state <= scorePkg::idle;
         endcase
      end
   end

endmodule

//--- logic/toneGenerator.sv
// square-wave generator for the piezo, driven by the current score entry
`timescale 1ns/1ps

module toneGenerator
#(
   parameter int periodShift = 0
)
(
   input  logic                CLK,
   input  logic                arstN,
   input  scorePkg::scoreEntry entry,
   input  logic                playing,
   input  logic                entryStart,
   output logic                piezo
);

   scorePkg::notePeriod halfPeriod;
   scorePkg::notePeriod toneCnt;
   logic silent;

   assign halfPeriod = entry.period >> periodShift;   // scaled for fast sim tempo
   assign silent     = !playing || (entry.period == scorePkg::restCode);

   always_ff @(posedge CLK or negedge arstN)
   begin
      if (!arstN)
      begin
         piezo   <= 1'b0;
         toneCnt <= '0;
      end
      else if (silent || entryStart)
      begin
         // each entry starts from a low output
         piezo   <= 1'b0;
         toneCnt <= '0;
      end
      else if (toneCnt == halfPeriod)
      begin
         piezo   <= ~piezo;
         toneCnt <= '0;
      end
      else
         toneCnt <= toneCnt + scorePkg::notePeriod'(1);
   end

endmodule

//--- logic/alarmPiezo.sv
// alarm tone player top level; plays the melody on PIEZO when the alarm time is reached
`timescale 1ns/1ps

module alarmPiezo
#(
   parameter int durationUnit = 62500,   // clocks per thirty-second note
   parameter int periodShift  = 0
)
(
   input  logic                   CLK,
   input  logic                   arstN,
   input  logic                   alarmActive,
   input  alarmTimePkg::timeField currentMin,
   input  alarmTimePkg::timeField currentSec,
   input  alarmTimePkg::timeField alarmMin,
   input  alarmTimePkg::timeField alarmSec,
   output logic                   PIEZO
);

   logic startPulse;
   logic stop;
   logic scoreDone;
   logic playing;
   logic entryStart;
   scorePkg::scoreIndex index;
   scorePkg::scoreEntry romEntry;
   scorePkg::scoreEntry entry;

   alarmTrigger trigger0
   (
      .CLK         (CLK),
      .arstN       (arstN),
      .alarmActive (alarmActive),
      .currentMin  (currentMin),
      .currentSec  (currentSec),
      .alarmMin    (alarmMin),
      .alarmSec    (alarmSec),
      .scoreDone   (scoreDone),
      .startPulse  (startPulse),
      .stop        (stop)
   );

   scoreSequencer #(.durationUnit(durationUnit)) sequencer0
   (
      .CLK        (CLK),
      .arstN      (arstN),
      .startPulse (startPulse),
      .stop       (stop),
      .index      (index),
      .romEntry   (romEntry),
      .entry      (entry),
      .playing    (playing),
      .entryStart (entryStart),
      .scoreDone  (scoreDone)
   );

   scoreRom rom0
   (
      .index (index),
      .entry (romEntry)
   );

   toneGenerator #(.periodShift(periodShift)) tone0
   (
      .CLK        (CLK),
      .arstN      (arstN),
      .entry      (entry),
      .playing    (playing),
      .entryStart (entryStart),
      .piezo      (PIEZO)
   );

endmodule

//--- tests/alarmPiezo_properties.sv
// assertions on the alarm tone player, bound to the top level at the end of this file
`timescale 1ns/1ps

module alarmPiezo_properties
(
   input logic CLK,
   input logic arstN,
   input logic alarmActive,
   input logic PIEZO,
   input logic startPulse,
   input logic playing,
   input logic entryStart
);

   // a disabled alarm silences the piezo at the next edge
   silentWhenDisabled: assert property (@(posedge CLK) disable iff (!arstN)
      !$past(alarmActive) |-> !PIEZO)
      else $error("PIEZO high one cycle after the alarm was disabled");

   noStartWhilePlaying: assert property (@(posedge CLK) disable iff (!arstN)
      startPulse |-> !playing)
      else $error("startPulse while the score is playing");

   quietEntryStart: assert property (@(posedge CLK) disable iff (!arstN)
      entryStart |=> !PIEZO ##1 !PIEZO)   // each entry begins low
      else $error("PIEZO moved right after entryStart");

endmodule

bind alarmPiezo alarmPiezo_properties props0
(
   .CLK         (CLK),
   .arstN       (arstN),
   .alarmActive (alarmActive),
   .PIEZO       (PIEZO),
   .startPulse  (startPulse),
   .playing     (playing),
   .entryStart  (entryStart)
);

//--- tests/alarmPiezoTb.sv
// testbench for the alarm tone player; runs the scenarios listed in tests/alarmPiezo_tests.txt
`timescale 1ns/1ps

module alarmPiezoTb;

   localparam int unitCycles = 256;
   localparam int fieldCount = 9;
   localparam int maxTests   = 16;
   localparam logic [15:0] randomTime = 16'h7F;   // current time drawn from the LFSR

   logic CLK = 1'b0;
   logic arstN;
   logic alarmActive;
   alarmTimePkg::timeField currentMin;
   alarmTimePkg::timeField currentSec;
   alarmTimePkg::timeField alarmMin;
   alarmTimePkg::timeField alarmSec;
   logic PIEZO;

   logic [15:0] testData [0:maxTests*fieldCount-1];
   logic [7:0]  lfsr;
   logic lastPiezo;
   int rises;
   int highCycles;
   int errors;
   int checks;
   int testCount;
   int cycleCount;
   int cycleLimit = 0;

   alarmPiezo #(.durationUnit(unitCycles), .periodShift(6)) dut0
   (
      .CLK         (CLK),
      .arstN       (arstN),
      .alarmActive (alarmActive),
      .currentMin  (currentMin),
      .currentSec  (currentSec),
      .alarmMin    (alarmMin),
      .alarmSec    (alarmSec),
      .PIEZO       (PIEZO)
   );

   always #20 CLK = ~CLK;

   // x^8 + x^6 + x^5 + x^4 + 1, shifting right
   function automatic logic [7:0] lfsrNext(input logic [7:0] s);
      return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
   endfunction

   task automatic takeBits(input int n, output int value);
      value = 0;
      repeat (n)
      begin
         lfsr  = lfsrNext(lfsr);
         value = (value << 1) | lfsr[0];
      end
   endtask

   // any minute and second apart from the alarm time
   task automatic pickOtherTime(output alarmTimePkg::timeField m, output alarmTimePkg::timeField s);
      int bits;
      m = alarmMin;
      s = alarmSec;
      while (m == alarmMin && s == alarmSec)
      begin
         takeBits(7, bits);
         m = alarmTimePkg::timeField'(bits % 60);
         takeBits(7, bits);
         s = alarmTimePkg::timeField'(bits % 60);
      end
   endtask

   task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] expected);
      checks++;
      if (got !== expected)
      begin
         errors++;
         $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
      end
   endtask

   // one clock, sampled on the falling edge
   task automatic stepCycle();
      @(negedge CLK);
      if (PIEZO === 1'b1 && lastPiezo !== 1'b1)
         rises++;
      if (PIEZO !== 1'b0)
         highCycles++;
      lastPiezo = PIEZO;
   endtask

   task automatic awaitStart(output bit started);
      int latency;
      latency = 0;
      started = 1'b0;
      while (!started && latency < 8)
      begin
         stepCycle();
         latency++;
         started = (dut0.playing === 1'b1);
      end
      if (started)
         checkValue("start latency", latency, 2);   // startPulse, then entry 0
      else
      begin
         errors++;
         $display("playback did not start within 8 cycles of the match at %0t ns", $time);
      end
   endtask

   // len counts cycles since the first playing cycle
   task automatic measureScore(input int expRises, input int units);
      int len;
      len   = 1;
      rises = 0;
      while (dut0.playing === 1'b1 && len <= units * unitCycles + 16)
      begin
         stepCycle();
         if (dut0.playing === 1'b1)
            len++;
         if (len > unitCycles && len <= 2 * unitCycles)
            checkValue("PIEZO in first rest", PIEZO, 0);
      end
      checkValue("score length", len, units * unitCycles);
      checkValue("PIEZO rising edges", rises, expRises);
      checkValue("PIEZO after score", PIEZO, 0);
   endtask

   task automatic playScore(input int expRises, input int units);
      bit started;
      awaitStart(started);
      if (started)
         measureScore(expRises, units);
   endtask

   function automatic int scenarioWindow(input int kind, input int units, input int cancelAt);
      int pass;
      pass = units * unitCycles + 32;
      case (kind)
         1: return pass + 8;
         3: return cancelAt + 2 * unitCycles + pass + 16;
         default: return 2 * pass + 16;
      endcase
   endfunction

   task automatic runScenario(input int t);
      logic [15:0] f [fieldCount];
      bit started;
      for (int i = 0; i < fieldCount; i++)
         f[i] = testData[t * fieldCount + i];
      alarmMin    = alarmTimePkg::timeField'(f[1]);
      alarmSec    = alarmTimePkg::timeField'(f[2]);
      alarmActive = 1'b0;   // lets the trigger re-arm
      pickOtherTime(currentMin, currentSec);
      repeat (4) stepCycle();
      checkValue("PIEZO before scenario", PIEZO, 0);
      if (f[3] == randomTime)
         pickOtherTime(currentMin, currentSec);
      else
      begin
         currentMin = alarmTimePkg::timeField'(f[3]);
         currentSec = alarmTimePkg::timeField'(f[4]);
      end
      alarmActive = f[5][0];
      rises       = 0;
      highCycles  = 0;
      case (f[0])
         1:
         begin
            repeat (f[8] * unitCycles + 16) stepCycle();
            checkValue("PIEZO rising edges", rises, f[7]);
            checkValue("PIEZO high cycles", highCycles, 0);
         end
         2:
         begin
            playScore(f[7], f[8]);
            rises = 0;
            repeat (f[8] * unitCycles + 16) stepCycle();   // still matching
            checkValue("PIEZO rising edges after score", rises, 0);
         end
         3:
         begin
            awaitStart(started);
            repeat (f[6]) stepCycle();
            alarmActive = 1'b0;
            repeat (2 * unitCycles)
            begin
               stepCycle();
               checkValue("PIEZO after cancel", PIEZO, 0);
            end
            alarmActive = 1'b1;
            playScore(f[7], f[8]);
         end
         4:
         begin
            playScore(f[7], f[8]);
            pickOtherTime(currentMin, currentSec);
            repeat (4) stepCycle();
            currentMin = alarmMin;
            currentSec = alarmSec;
            playScore(f[7], f[8]);
         end
         default:
         begin
            errors++;
            $display("unknown scenario kind %0d on data line %0d", f[0], t + 1);
         end
      endcase
   endtask

   initial
   begin
      int limit;
      arstN       = 1'b0;
      alarmActive = 1'b0;
      currentMin  = '0;
      currentSec  = '0;
      alarmMin    = '0;
      alarmSec    = '0;
      lfsr        = 8'd73;
      lastPiezo   = 1'b0;
      rises       = 0;
      highCycles  = 0;
      errors      = 0;
      checks      = 0;
      testCount   = 0;
      for (int i = 0; i < maxTests * fieldCount; i++)
         testData[i] = '0;
      $readmemh("tests/alarmPiezo_tests.txt", testData);
      while (testCount < maxTests && testData[testCount * fieldCount] != 0)
         testCount++;
      if (testCount == 0)
      begin
         errors++;
         $display("no scenarios found in the test data file");
      end
      limit = 100;   // reset plus margin
      for (int t = 0; t < testCount; t++)
         limit += scenarioWindow(testData[t * fieldCount], testData[t * fieldCount + 8],
                                 testData[t * fieldCount + 6]);
      cycleLimit = limit;
      repeat (8) stepCycle();
      checkValue("PIEZO in reset", PIEZO, 0);
      checkValue("playing in reset", dut0.playing, 0);
      checkValue("startPulse in reset", dut0.startPulse, 0);
      checkValue("scoreDone in reset", dut0.scoreDone, 0);
      checkValue("armed in reset", dut0.trigger0.armed, 0);
      arstN = 1'b1;
      for (int t = 0; t < testCount; t++)
         runScenario(t);
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

   initial
   begin
      cycleCount = 0;
      wait (cycleLimit > 0);
      while (cycleCount < cycleLimit)
      begin
         @(posedge CLK);
         cycleCount++;
      end
      $display("timeout, the run went past %0d cycles", cycleLimit);
      $display("Done: errors found");
      $finish;
   end

endmodule

//--- tests/alarmPiezo_tests.txt
// kind alarmMin alarmSec curMin curSec enable cancelAt rises units, all hex
// kind 1 watch, 2 play then hold, 3 cancel then re-enable, 4 play, move away and back
// curMin 7F means a random current time that differs from the alarm time
1 06 1E 7F 7F 1 00 00 20
1 06 1E 06 1E 0 00 00 20
1 0C 05 0C 06 1 00 00 20
2 07 00 07 00 1 00 30 20
3 0B 2D 0B 2D 1 AA 30 20
4 17 3B 17 3B 1 00 30 20

//--- vlog.f
logic/alarmTimePkg.sv
logic/scorePkg.sv
logic/alarmTrigger.sv
logic/scoreRom.sv
logic/scoreSequencer.sv
logic/toneGenerator.sv
logic/alarmPiezo.sv
tests/alarmPiezo_properties.sv
tests/alarmPiezoTb.sv

//--- Bender.yml
package:
  name: alarm_piezo

sources:
  - logic/alarmTimePkg.sv
  - logic/scorePkg.sv
  - logic/alarmTrigger.sv
  - logic/scoreRom.sv
  - logic/scoreSequencer.sv
  - logic/toneGenerator.sv
  - logic/alarmPiezo.sv
  - target: test
    files:
      - tests/alarmPiezo_properties.sv
      - tests/alarmPiezoTb.sv
